// File: tb.f
verilog/icache_pkg.sv
verilog/icache_replacement.sv
verilog/icache_array.sv
verilog/icache_ctrl_en.sv
verilog/icache_ctrl_unit.sv
verilog/icache_top.sv
tb/tb_icache.sv

// File: tb/tb_icache.sv
// ==========================================================================
// Instruction cache testbench: i-TLB and L2 models, directed fetch tests
// ==========================================================================
`timescale 1ns/100ps

module tb_icache;

    localparam int TIMEOUT_CYCLES = 200;
    // Translation used by the i-TLB model
    localparam logic [icache_pkg::PPN_W-1:0] PPN_MASK = 20'h3_c5a1;

    typedef enum logic [1:0] {
        L2Idle,
        L2Accept,
        L2Taken,
        L2Answer
    } l2_state_e;

    logic                          clk_i;
    logic                          rst_i;
    logic                          fend_valid_i;
    icache_pkg::fetch_vaddr_t      fend_vaddr_i;
    logic                          fend_req_rdy_o;
    logic                          fend_ans_valid_o;
    icache_pkg::fend_ans_t         fend_ans_o;
    logic [icache_pkg::VPN_W-1:0]  itlb_vpn_o;
    logic                          itlb_rdy_i;
    logic                          itlb_hit_i;
    icache_pkg::exception_e        itlb_exception_i;
    logic [icache_pkg::PPN_W-1:0]  itlb_ppn_i;
    logic                          l2c_req_valid_o;
    icache_pkg::l2c_req_t          l2c_req_o;
    logic                          l2c_req_rdy_i;
    logic                          l2c_ans_valid_i;
    icache_pkg::l2c_ans_t          l2c_ans_i;

    // Model state
    l2_state_e                     l2_state;
    int unsigned                   l2_cnt;
    int unsigned                   tlb_wait;
    logic                          tlb_delay_en;
    logic [31:0]                   lfsr_q;
    int unsigned                   cycle_cnt;
    // Seen L2 requests and front-end answers, with answer cycles
    icache_pkg::l2c_req_t          l2_req_q[$];
    icache_pkg::fend_ans_t         ans_q[$];
    int unsigned                   ans_cyc_q[$];

    icache_top u_dut (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .fend_valid_i     (fend_valid_i),
        .fend_vaddr_i     (fend_vaddr_i),
        .fend_req_rdy_o   (fend_req_rdy_o),
        .fend_ans_valid_o (fend_ans_valid_o),
        .fend_ans_o       (fend_ans_o),
        .itlb_vpn_o       (itlb_vpn_o),
        .itlb_rdy_i       (itlb_rdy_i),
        .itlb_hit_i       (itlb_hit_i),
        .itlb_exception_i (itlb_exception_i),
        .itlb_ppn_i       (itlb_ppn_i),
        .l2c_req_valid_o  (l2c_req_valid_o),
        .l2c_req_o        (l2c_req_o),
        .l2c_req_rdy_i    (l2c_req_rdy_i),
        .l2c_ans_valid_i  (l2c_ans_valid_i),
        .l2c_ans_i        (l2c_ans_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    // Answers sampled mid-cycle, stamped with the cycle number
    always @(negedge clk_i) begin
        if (fend_ans_valid_o === 1'b1) begin
            ans_q.push_back(fend_ans_o);
            ans_cyc_q.push_back(cycle_cnt);
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf("mismatch at %0t ns: %s: got %0h, expected %0h",
                                    $time, what, actual, expected));
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic int unsigned draw_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) v = (v << 1) | lfsr_bit();
        return v;
    endfunction

    // L2 content: line address, word number and a constant tail
    function automatic logic [31:0] model_word(input icache_pkg::l2c_req_t addr, input int w);
        return {addr, w[1:0], 7'h2d};
    endfunction

    function automatic icache_pkg::l2c_ans_t model_line(input icache_pkg::l2c_req_t addr);
        icache_pkg::l2c_ans_t l;
        for (int w = 0; w < icache_pkg::WORDS_PER_LINE; w++) begin
            l.line[w*icache_pkg::WORD_W +: icache_pkg::WORD_W] = model_word(addr, w);
        end
        return l;
    endfunction

    // Physical line address as the i-TLB model translates it
    function automatic icache_pkg::l2c_req_t line_addr(input icache_pkg::fetch_vaddr_t va);
        icache_pkg::l2c_req_t a;
        a.ppn = va.vpn ^ PPN_MASK;
        a.idx = va.idx;
        return a;
    endfunction

    function automatic icache_pkg::fend_ans_t expected_answer(input icache_pkg::fetch_vaddr_t va);
        icache_pkg::fend_ans_t a;
        a.vaddr = va;
        if (va.vpn[icache_pkg::VPN_W-1]) begin
            a.instr     = '0;
            a.exception = icache_pkg::PageFault;
        end else begin
            a.instr     = model_word(line_addr(va), va.word_off);
            a.exception = icache_pkg::NoException;
        end
        return a;
    endfunction

    function automatic icache_pkg::fetch_vaddr_t make_vaddr(input logic [19:0] vpn, input int idx,
                                                           input int word);
        icache_pkg::fetch_vaddr_t va;
        va.vpn      = vpn;
        va.unused   = 5'h16;
        va.idx      = icache_pkg::IDX_W'(idx);
        va.word_off = icache_pkg::OFFSET_W'(word);
        va.byte_off = '0;
        return va;
    endfunction

    // i-TLB: vpn XOR mask, top vpn bit faults, readiness from the delay counter
    always_comb begin
        itlb_hit_i       = 1'b1;
        itlb_ppn_i       = itlb_vpn_o ^ PPN_MASK;
        itlb_exception_i = itlb_vpn_o[icache_pkg::VPN_W-1] ? icache_pkg::PageFault
                                                          : icache_pkg::NoException;
        itlb_rdy_i       = tlb_wait == 0;
    end

    // Sample at the falling edge, drive just after the rising edge
    always begin
        logic                 s_accept;
        logic                 s_valid;
        icache_pkg::l2c_req_t s_req;
        @(negedge clk_i);
        s_accept = fend_valid_i && fend_req_rdy_o;
        s_valid  = l2c_req_valid_o;
        s_req    = l2c_req_o;
        @(posedge clk_i);
        #1;
        // New i-TLB latency for each accepted fetch
        if (s_accept === 1'b1) begin
            tlb_wait = tlb_delay_en ? draw_bits(2) : 0;
        end else if (tlb_wait != 0) begin
            tlb_wait--;
        end
        l2c_ans_valid_i = 1'b0;
        case (l2_state)
            L2Idle: begin
                if (s_valid === 1'b1) begin
                    l2_req_q.push_back(s_req);
                    l2_cnt   = draw_bits(2) % 3;
                    l2_state = L2Accept;
                end
            end
            L2Accept: begin
                // Request held until taken
                check_equal(s_valid, 1'b1, "L2 request valid while waiting");
                check_equal(s_req, l2_req_q[$], "L2 request while waiting");
                if (l2_cnt == 0) begin
                    l2c_req_rdy_i = 1'b1;
                    l2_state      = L2Taken;
                end else begin
                    l2_cnt--;
                end
            end
            L2Taken: begin
                check_equal(s_valid, 1'b1, "L2 request valid at accept");
                l2c_req_rdy_i = 1'b0;
                l2_cnt        = 1 + draw_bits(3);
                l2_state      = L2Answer;
            end
            default: begin
                if (l2_cnt == 0) begin
                    l2c_ans_valid_i = 1'b1;
                    l2c_ans_i       = model_line(l2_req_q[$]);
                    l2_state        = L2Idle;
                end else begin
                    l2_cnt--;
                end
            end
        endcase
    end

    // Leaves valid high, returns just after the accepting edge
    task automatic send_request(input icache_pkg::fetch_vaddr_t va);
        logic accepted;
        accepted     = 1'b0;
        fend_valid_i = 1'b1;
        fend_vaddr_i = va;
        for (int t = 0; t < TIMEOUT_CYCLES && !accepted; t++) begin
            @(negedge clk_i);
            accepted = fend_req_rdy_o === 1'b1;
            @(posedge clk_i);
            #1;
        end
        if (!accepted) stop_on_error("timeout: fetch request never accepted");
    endtask

    task automatic wait_answers(input int n);
        int unsigned waited;
        waited = 0;
        while (ans_q.size() < n) begin
            if (waited == TIMEOUT_CYCLES) stop_on_error("timeout: no answer from the cache");
            @(posedge clk_i);
            #1;
            waited++;
        end
    endtask

    task automatic check_next_answer(input icache_pkg::fetch_vaddr_t va,
                                     output int unsigned cyc);
        icache_pkg::fend_ans_t ans;
        ans = ans_q.pop_front();
        cyc = ans_cyc_q.pop_front();
        check_equal(ans, expected_answer(va), $sformatf("answer for vaddr %0h", va));
    endtask

    // One fetch, its answer and the L2 traffic it causes
    task automatic fetch_expect(input icache_pkg::fetch_vaddr_t va, input logic expect_miss);
        int unsigned reqs_before;
        int unsigned cyc;
        reqs_before = l2_req_q.size();
        send_request(va);
        fend_valid_i = 1'b0;
        wait_answers(1);
        check_next_answer(va, cyc);
        check_equal(l2_req_q.size() - reqs_before, expect_miss, "number of L2 requests");
        if (expect_miss) check_equal(l2_req_q[$], line_addr(va), "L2 line address");
    endtask

    task automatic test_reset_and_first_miss();
        int unsigned low_cycles;
        logic        ready;
        low_cycles = 0;
        ready      = 1'b0;
        @(negedge clk_i);
        check_equal(l2c_req_valid_o, 1'b0, "L2 request valid after reset");
        check_equal(fend_ans_valid_o, 1'b0, "answer valid after reset");
        // One set invalidated per cycle
        while (!ready) begin
            if (fend_req_rdy_o === 1'b1) begin
                ready = 1'b1;
            end else begin
                low_cycles++;
                if (low_cycles > TIMEOUT_CYCLES) stop_on_error("timeout: cache never ready");
                @(negedge clk_i);
            end
        end
        check_equal(low_cycles, icache_pkg::SETS, "cycles with ready low after reset");
        @(posedge clk_i);
        #1;
        fetch_expect(make_vaddr(20'h1_2345, 3, 1), 1'b1);
    endtask

    task automatic test_hit_stream();
        int unsigned reqs_before;
        int unsigned accept_cyc;
        int unsigned cyc0;
        int unsigned cyc;
        reqs_before = l2_req_q.size();
        accept_cyc  = 0;
        // Every word of the filled line, back to back
        for (int w = 0; w < icache_pkg::WORDS_PER_LINE; w++) begin
            send_request(make_vaddr(20'h1_2345, 3, w));
            if (w == 0) accept_cyc = cycle_cnt;
        end
        fend_valid_i = 1'b0;
        wait_answers(icache_pkg::WORDS_PER_LINE);
        check_next_answer(make_vaddr(20'h1_2345, 3, 0), cyc0);
        // Hit answered in the cycle right after the accepting edge
        check_equal(cyc0, accept_cyc, "cycle of the first hit");
        for (int w = 1; w < icache_pkg::WORDS_PER_LINE; w++) begin
            check_next_answer(make_vaddr(20'h1_2345, 3, w), cyc);
            check_equal(cyc, cyc0 + w, "cycle of a streamed hit");
        end
        check_equal(l2_req_q.size(), reqs_before, "L2 requests during hits");
    endtask

    task automatic test_round_robin();
        // Three lines in set 5, third one evicts the first
        fetch_expect(make_vaddr(20'h0_0100, 5, 0), 1'b1);
        fetch_expect(make_vaddr(20'h0_0200, 5, 1), 1'b1);
        fetch_expect(make_vaddr(20'h0_0300, 5, 2), 1'b1);
        fetch_expect(make_vaddr(20'h0_0200, 5, 3), 1'b0);
        fetch_expect(make_vaddr(20'h0_0100, 5, 0), 1'b1);
    endtask

    task automatic test_page_fault();
        fetch_expect(make_vaddr(20'h8_0042, 2, 1), 1'b0);
        fetch_expect(make_vaddr(20'h1_2345, 3, 2), 1'b0);
        fetch_expect(make_vaddr(20'h0_0777, 2, 3), 1'b1);
    endtask

    task automatic test_delays();
        tlb_delay_en = 1'b1;
        // Fill then reuse, both with random i-TLB and L2 latency
        for (int i = 0; i < 6; i++) begin
            fetch_expect(make_vaddr(20'(20'h0_4000 + i), i, i % 4), 1'b1);
            fetch_expect(make_vaddr(20'(20'h0_4000 + i), i, (i + 1) % 4), 1'b0);
        end
        fetch_expect(make_vaddr(20'hf_0001, 6, 2), 1'b0);
        fetch_expect(make_vaddr(20'h1_2345, 3, 3), 1'b0);
        tlb_delay_en = 1'b0;
    endtask

    initial begin
        lfsr_q          = 32'h101b_119e;
        cycle_cnt       = 0;
        tlb_wait        = 0;
        tlb_delay_en    = 1'b0;
        l2_state        = L2Idle;
        l2_cnt          = 0;
        rst_i           = 1'b1;
        fend_valid_i    = 1'b0;
        fend_vaddr_i    = '0;
        l2c_req_rdy_i   = 1'b0;
        l2c_ans_valid_i = 1'b0;
        l2c_ans_i       = '0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        test_reset_and_first_miss();
        test_hit_stream();
        test_round_robin();
        test_page_fault();
        test_delays();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: verilog/icache_top.sv
// ==========================================================================
// Instruction cache top: address and tag registers, answer and L2 request
// ==========================================================================
`timescale 1ns/100ps

module icache_top (
    input  logic                         clk_i,
    input  logic                         rst_i,
    // Front-end
    input  logic                         fend_valid_i,
    input  icache_pkg::fetch_vaddr_t     fend_vaddr_i,
    output logic                         fend_req_rdy_o,
    output logic                         fend_ans_valid_o,
    output icache_pkg::fend_ans_t        fend_ans_o,
    // i-TLB, answered combinationally
    output logic [icache_pkg::VPN_W-1:0] itlb_vpn_o,
    input  logic                         itlb_rdy_i,
    input  logic                         itlb_hit_i,
    input  icache_pkg::exception_e       itlb_exception_i,
    input  logic [icache_pkg::PPN_W-1:0] itlb_ppn_i,
    // L2
    output logic                         l2c_req_valid_o,
    output icache_pkg::l2c_req_t         l2c_req_o,
    input  logic                         l2c_req_rdy_i,
    input  logic                         l2c_ans_valid_i,
    input  icache_pkg::l2c_ans_t         l2c_ans_i
);

    icache_pkg::icache_ctrl_e     icache_cond_ctrl;
    logic                         icache_cond_ctrl_en;
    logic                         comparing;
    logic                         replaying;
    logic                         waiting_tlb;
    logic                         waiting_l2c;
    logic [icache_pkg::IDX_W-1:0] inv_idx;
    logic                         cache_hit;
    logic [icache_pkg::WORD_W-1:0] word;
    logic                         update_replacement;
    logic                         vaddr_reg_en;
    logic                         tag_reg_en;
    logic [icache_pkg::WAY_W-1:0] victim_way;
    logic [icache_pkg::IDX_W-1:0] index;

    // Request being served, plus tag and victim of a pending miss
    icache_pkg::fetch_vaddr_t     vaddr_q;
    logic [icache_pkg::PPN_W-1:0] tag_q;
    logic [icache_pkg::WAY_W-1:0] victim_q;

    always_ff @(posedge clk_i) begin
        if (vaddr_reg_en) vaddr_q <= fend_vaddr_i;
        if (tag_reg_en) begin
            tag_q    <= itlb_ppn_i;
            victim_q <= victim_way;
        end
    end

    // Incoming index on an accept, else the held one
    assign index = vaddr_reg_en ? fend_vaddr_i.idx : vaddr_q.idx;

    assign itlb_vpn_o = vaddr_q.vpn;

    // Exceptions answer with a zero word
    assign fend_ans_o.instr     = (itlb_exception_i != icache_pkg::NoException) ? '0 : word;
    assign fend_ans_o.exception = itlb_exception_i;
    assign fend_ans_o.vaddr     = vaddr_q;

    // Both fields stay put while the request waits
    assign l2c_req_o.ppn = tag_q;
    assign l2c_req_o.idx = vaddr_q.idx;

    icache_ctrl_unit u_ctrl_unit (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .cache_hit_i        (cache_hit),
        .itlb_rdy_i         (itlb_rdy_i),
        .itlb_hit_i         (itlb_hit_i),
        .itlb_exception_i   (itlb_exception_i),
        .l2c_req_rdy_i      (l2c_req_rdy_i),
        .l2c_ans_valid_i    (l2c_ans_valid_i),
        .fend_valid_i       (fend_valid_i),
        .icache_cond_ctrl_o (icache_cond_ctrl),
        .comparing_o        (comparing),
        .replaying_o        (replaying),
        .waiting_tlb_o      (waiting_tlb),
        .waiting_l2c_o      (waiting_l2c),
        .l2c_req_valid_o    (l2c_req_valid_o),
        .inv_idx_o          (inv_idx)
    );

    icache_ctrl_en u_ctrl_en (
        .icache_cond_ctrl_i    (icache_cond_ctrl),
        .comparing_i           (comparing),
        .replaying_i           (replaying),
        .waiting_tlb_i         (waiting_tlb),
        .waiting_l2c_i         (waiting_l2c),
        .cache_hit_i           (cache_hit),
        .itlb_hit_i            (itlb_hit_i),
        .itlb_exception_i      (itlb_exception_i),
        .itlb_rdy_i            (itlb_rdy_i),
        .l2c_ans_valid_i       (l2c_ans_valid_i),
        .fend_valid_i          (fend_valid_i),
        .icache_cond_ctrl_en_o (icache_cond_ctrl_en),
        .fend_req_rdy_o        (fend_req_rdy_o),
        .fend_ans_valid_o      (fend_ans_valid_o),
        .update_replacement_o  (update_replacement),
        .vaddr_reg_en_o        (vaddr_reg_en),
        .tag_reg_en_o          (tag_reg_en)
    );

    icache_array u_array (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .op_i       (icache_cond_ctrl),
        .op_en_i    (icache_cond_ctrl_en),
        .index_i    (index),
        .inv_idx_i  (inv_idx),
        .word_sel_i (vaddr_q.word_off),
        .ppn_i      (itlb_ppn_i),
        .wr_way_i   (victim_q),
        .wr_tag_i   (tag_q),
        .wr_line_i  (l2c_ans_i),
        .hit_o      (cache_hit),
        .word_o     (word)
    );

    icache_replacement u_replacement (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .index_i      (vaddr_q.idx),
        .update_i     (update_replacement),
        .victim_way_o (victim_way)
    );

endmodule

// File: verilog/icache_ctrl_unit.sv
// ==========================================================================
// Instruction cache control unit: invalidation walk and lookup mode FSM
// ==========================================================================
`timescale 1ns/100ps

module icache_ctrl_unit (
    input  logic                         clk_i,
    input  logic                         rst_i,
    // Lookup status from the array and the i-TLB
    input  logic                         cache_hit_i,
    input  logic                         itlb_rdy_i,
    input  logic                         itlb_hit_i,
    input  icache_pkg::exception_e       itlb_exception_i,
    // L2 handshake
    input  logic                         l2c_req_rdy_i,
    input  logic                         l2c_ans_valid_i,
    // Front-end request strobe
    input  logic                         fend_valid_i,
    // Scheduled operation and mode levels
    output icache_pkg::icache_ctrl_e     icache_cond_ctrl_o,
    output logic                         comparing_o,
    output logic                         replaying_o,
    output logic                         waiting_tlb_o,
    output logic                         waiting_l2c_o,
    output logic                         l2c_req_valid_o,
    output logic [icache_pkg::IDX_W-1:0] inv_idx_o
);

    typedef enum logic [2:0] {
        StInvalidate,
        StReady,
        StCompare,
        StWaitTlb,
        StL2Req,
        StWaitL2,
        StReplay
    } state_e;

    state_e                       state_q;
    state_e                       state_d;
    logic [icache_pkg::IDX_W-1:0] inv_cnt_q;
    logic                         tlb_exc;
    logic                         answer;

    assign tlb_exc = itlb_exception_i != icache_pkg::NoException;
    // Exception or translated hit, both answered in the comparing cycle
    assign answer  = itlb_rdy_i && (tlb_exc || (itlb_hit_i && cache_hit_i));

    always_comb begin
        state_d = state_q;
        case (state_q)
            // One set cleared per cycle
            StInvalidate: begin
                if (inv_cnt_q == icache_pkg::LAST_SET) state_d = StReady;
            end
            StReady: begin
                if (fend_valid_i) state_d = StCompare;
            end
            StCompare: begin
                if (answer) begin
                    // Stream the next request straight into comparing
                    state_d = fend_valid_i ? StCompare : StReady;
                end else if (itlb_rdy_i && itlb_hit_i) begin
                    state_d = StL2Req;
                end else begin
                    state_d = StWaitTlb;
                end
            end
            // Set is read again on the ready cycle
            StWaitTlb: begin
                if (itlb_rdy_i) state_d = StCompare;
            end
            // Request held valid until the L2 takes it
            StL2Req: begin
                if (l2c_req_rdy_i) state_d = StWaitL2;
            end
            // Line written at the answer edge
            StWaitL2: begin
                if (l2c_ans_valid_i) state_d = StReplay;
            end
            StReplay: state_d = StCompare;
            default:  state_d = StInvalidate;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= StInvalidate;
            inv_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == StInvalidate) inv_cnt_q <= inv_cnt_q + 1'b1;
        end
    end

    // Memory operation follows the state
    always_comb begin
        icache_cond_ctrl_o = icache_pkg::ReadSet;
        if (state_q == StInvalidate) begin
            icache_cond_ctrl_o = icache_pkg::InvalidSet;
        end else if (state_q == StWaitL2) begin
            icache_cond_ctrl_o = icache_pkg::WriteLineAndTag;
        end
    end

    assign comparing_o     = state_q == StCompare;
    assign replaying_o     = state_q == StReplay;
    assign waiting_tlb_o   = state_q == StWaitTlb;
    assign waiting_l2c_o   = (state_q == StL2Req) || (state_q == StWaitL2);
    assign l2c_req_valid_o = state_q == StL2Req;
    assign inv_idx_o       = inv_cnt_q;

endmodule

// File: verilog/icache_ctrl_en.sv
// ==========================================================================
// Instruction cache enables: memory strobe, front-end handshake, register
// and replacement updates
// ==========================================================================
`timescale 1ns/100ps

module icache_ctrl_en (
    // Operation and modes from the control unit
    input  icache_pkg::icache_ctrl_e icache_cond_ctrl_i,
    input  logic                     comparing_i,
    input  logic                     replaying_i,
    input  logic                     waiting_tlb_i,
    input  logic                     waiting_l2c_i,
    // Lookup status
    input  logic                     cache_hit_i,
    input  logic                     itlb_hit_i,
    input  icache_pkg::exception_e   itlb_exception_i,
    input  logic                     itlb_rdy_i,
    // L2 answer strobe
    input  logic                     l2c_ans_valid_i,
    // Front-end request strobe
    input  logic                     fend_valid_i,
    // Actual strobe of the scheduled operation
    output logic                     icache_cond_ctrl_en_o,
    // Front-end handshake
    output logic                     fend_req_rdy_o,
    output logic                     fend_ans_valid_o,
    // Datapath updates
    output logic                     update_replacement_o,
    output logic                     vaddr_reg_en_o,
    output logic                     tag_reg_en_o
);

    logic tlb_exc;
    logic answer;
    logic miss;

    assign tlb_exc = itlb_exception_i != icache_pkg::NoException;
    assign answer  = itlb_rdy_i && (tlb_exc || (itlb_hit_i && cache_hit_i));
    // Translated but not cached
    assign miss    = itlb_rdy_i && !tlb_exc && itlb_hit_i && !cache_hit_i;

    // Mealy outputs of the control unit, kept in the datapath
    always_comb begin
        icache_cond_ctrl_en_o = 1'b0;
        fend_req_rdy_o        = 1'b0;
        fend_ans_valid_o      = 1'b0;
        update_replacement_o  = 1'b0;
        vaddr_reg_en_o        = 1'b0;
        tag_reg_en_o          = 1'b0;
        case (icache_cond_ctrl_i)
            icache_pkg::ReadSet: begin
                if (comparing_i) begin
                    // Answer and free the port in the same cycle
                    fend_ans_valid_o     = answer;
                    fend_req_rdy_o       = answer;
                    // Latch tag and victim, advance round-robin
                    tag_reg_en_o         = miss;
                    update_replacement_o = miss;
                end else if (replaying_i) begin
                    icache_cond_ctrl_en_o = 1'b1;
                end else if (waiting_tlb_i) begin
                    icache_cond_ctrl_en_o = itlb_rdy_i;
                end else if (waiting_l2c_i) begin
                    icache_cond_ctrl_en_o = 1'b1;
                end else begin
                    // Idle and ready
                    fend_req_rdy_o = 1'b1;
                end
                // Accepted request reads its set at this edge
                if (fend_req_rdy_o && fend_valid_i) begin
                    icache_cond_ctrl_en_o = 1'b1;
                    vaddr_reg_en_o        = 1'b1;
                end
            end
            icache_pkg::WriteLineAndTag: begin
                icache_cond_ctrl_en_o = l2c_ans_valid_i;
            end
            icache_pkg::InvalidSet: begin
                icache_cond_ctrl_en_o = 1'b1;
            end
            default: begin
                icache_cond_ctrl_en_o = 1'b0;
            end
        endcase
    end

endmodule

// File: verilog/icache_array.sv
// ==========================================================================
// Instruction cache array: two-way tag, valid and line storage with a
// registered set read, tag compare and word select
// ==========================================================================
`timescale 1ns/100ps

module icache_array (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Operation and its strobe
    input  icache_pkg::icache_ctrl_e        op_i,
    input  logic                            op_en_i,
    input  logic [icache_pkg::IDX_W-1:0]    index_i,
    input  logic [icache_pkg::IDX_W-1:0]    inv_idx_i,
    // Compare side
    input  logic [icache_pkg::OFFSET_W-1:0] word_sel_i,
    input  logic [icache_pkg::PPN_W-1:0]    ppn_i,
    // Refill side
    input  logic [icache_pkg::WAY_W-1:0]    wr_way_i,
    input  logic [icache_pkg::PPN_W-1:0]    wr_tag_i,
    input  icache_pkg::l2c_ans_t            wr_line_i,
    output logic                            hit_o,
    output logic [icache_pkg::WORD_W-1:0]   word_o
);

    // Storage, valid bits grouped per set
    logic [icache_pkg::WAYS-1:0]   valid_mem [icache_pkg::SETS];
    logic [icache_pkg::PPN_W-1:0]  tag_mem   [icache_pkg::WAYS][icache_pkg::SETS];
    logic [icache_pkg::LINE_W-1:0] line_mem  [icache_pkg::WAYS][icache_pkg::SETS];

    // Registered copy of the set being compared
    logic [icache_pkg::WAYS-1:0]   rd_valid_q;
    logic [icache_pkg::PPN_W-1:0]  rd_tag_q  [icache_pkg::WAYS];
    logic [icache_pkg::LINE_W-1:0] rd_line_q [icache_pkg::WAYS];
    logic [icache_pkg::WAYS-1:0]   way_hit;

    logic do_read;
    logic do_write;
    logic do_inval;

    assign do_read  = op_en_i && (op_i == icache_pkg::ReadSet);
    assign do_write = op_en_i && (op_i == icache_pkg::WriteLineAndTag);
    assign do_inval = op_en_i && (op_i == icache_pkg::InvalidSet);

    // Refill fills the victim way, invalidate clears both ways of a set
    always_ff @(posedge clk_i) begin
        if (do_write) begin
            valid_mem[index_i][wr_way_i] <= 1'b1;
            tag_mem[wr_way_i][index_i]   <= wr_tag_i;
            line_mem[wr_way_i][index_i]  <= wr_line_i.line;
        end
        if (do_inval) valid_mem[inv_idx_i] <= '0;
    end

    // Set read, held until the next ReadSet strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_valid_q <= '0;
        end else if (do_read) begin
            rd_valid_q <= valid_mem[index_i];
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                rd_tag_q[w]  <= tag_mem[w][index_i];
                rd_line_q[w] <= line_mem[w][index_i];
            end
        end
    end

    // Physical tag compare against the i-TLB page number
    always_comb begin
        hit_o  = 1'b0;
        word_o = '0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            way_hit[w] = rd_valid_q[w] && (rd_tag_q[w] == ppn_i);
            // At most one way holds a given tag
            if (way_hit[w]) begin
                hit_o  = 1'b1;
                word_o = rd_line_q[w][word_sel_i*icache_pkg::WORD_W +: icache_pkg::WORD_W];
            end
        end
    end

endmodule

// File: verilog/icache_replacement.sv
// ==========================================================================
// Instruction cache replacement: per-set round-robin victim way
// ==========================================================================
`timescale 1ns/100ps

module icache_replacement (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [icache_pkg::IDX_W-1:0] index_i,
    // Set gets a new line, move its pointer on
    input  logic                         update_i,
    output logic [icache_pkg::WAY_W-1:0] victim_way_o
);

    // Next way to fill, one pointer per set
    logic [icache_pkg::WAY_W-1:0] next_way_q [icache_pkg::SETS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            next_way_q <= '{default: '0};
        end else if (update_i) begin
            next_way_q[index_i] <= next_way_q[index_i] + 1'b1;
        end
    end

    // Value before the toggle, sampled along with the tag
    assign victim_way_o = next_way_q[index_i];

endmodule

// File: verilog/icache_pkg.sv
// ==========================================================================
// Instruction cache package: geometry, operation and exception codes, and
// the front-end and L2 transfer structs
// ==========================================================================
package icache_pkg;

    // Cache geometry
    localparam int WAYS           = 2;
    localparam int WAY_W          = $clog2(WAYS);
    localparam int SETS           = 8;
    localparam int IDX_W          = $clog2(SETS);
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_W         = 32;
    localparam int OFFSET_W       = $clog2(WORDS_PER_LINE);
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;

    // Last set touched by the invalidation walk
    localparam logic [IDX_W-1:0] LAST_SET = IDX_W'(SETS - 1);

    // Address widths
    localparam int VADDR_W  = 32;
    localparam int VPN_W    = 20;
    localparam int PPN_W    = 20;
    localparam int BYTE_W   = $clog2(WORD_W / 8);
    // Page offset bits above the set index, ignored by the lookup
    localparam int UNUSED_W = VADDR_W - VPN_W - IDX_W - OFFSET_W - BYTE_W;

    // Memory operation scheduled by the control unit
    typedef enum logic [1:0] {
        ReadSet,
        WriteLineAndTag,
        InvalidSet
    } icache_ctrl_e;

    // Exception code from the i-TLB
    typedef enum logic [1:0] {
        NoException = 2'd0,
        PageFault   = 2'd1,
        AccessFault = 2'd2
    } exception_e;

    typedef struct packed {
        logic [VPN_W-1:0]    vpn;
        logic [UNUSED_W-1:0] unused;
        logic [IDX_W-1:0]    idx;
        logic [OFFSET_W-1:0] word_off;
        logic [BYTE_W-1:0]   byte_off;
    } fetch_vaddr_t;

    // Answer to the front-end, with the request address echoed back
    typedef struct packed {
        logic [WORD_W-1:0] instr;
        exception_e        exception;
        fetch_vaddr_t      vaddr;
    } fend_ans_t;

    // Physical line address sent to the L2
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [IDX_W-1:0] idx;
    } l2c_req_t;

    typedef struct packed {
        logic [LINE_W-1:0] line;
    } l2c_ans_t;

endpackage
